/* include/scaler_config.svh */
`ifndef SCALER_CONFIG_SVH
`define SCALER_CONFIG_SVH

// pixel width in bits
`define SCALER_DATA_WIDTH 8

// weight magnitude width, unity weight is 1 << (width - 1)
`define SCALER_COE_WIDTH 10

// depth of each of the five line buffers
`define SCALER_LINE_MAX 64

// phase index width, taken from bits 11..7 of the output coordinate
`define SCALER_PHASE_BITS 5

// idle cycles between two output pixels
`define SCALER_SPARSE 2

// input line step in 4.12, unity
`define SCALER_STEP_IN 4096

`endif

/* hdl/scaler_pkg.sv */
`default_nettype none

`include "scaler_config.svh"

package scaler_pkg;

    // one raw pixel
    typedef logic [`SCALER_DATA_WIDTH-1:0] pixel_t;

    // one weight magnitude, sign fixed by tap position
    typedef logic [`SCALER_COE_WIDTH-1:0] coe_t;

    // line buffer address
    typedef logic [$clog2(`SCALER_LINE_MAX)-1:0] addr_t;

    // four weights in tap order
    typedef struct packed {
        coe_t c0;
        coe_t c1;
        coe_t c2;
        coe_t c3;
    } coe_set_t;

    // pixel with its video timing strobes
    typedef struct packed {
        pixel_t data;
        logic   de;
        logic   hs;
        logic   vs;
    } video_beat_t;

    // runtime config, held for a whole frame
    typedef struct packed {
        logic [15:0] step_o;
        logic [15:0] line_size;
    } scale_cfg_t;

    // read request from sequencer to line store
    typedef struct packed {
        logic  valid;
        logic  first;
        addr_t addr;
    } rd_req_t;

    // taps[0] newest complete line .. taps[3] oldest
    typedef struct packed {
        pixel_t [3:0] taps;
        logic         de;
        logic         hs;
        logic         vs;
    } tap_beat_t;

endpackage

`default_nettype wire

/* hdl/line_store.sv */
`timescale 1ns/10ps
`default_nettype none

`include "scaler_config.svh"

module line_store (
    input  wire                     clk,
    input  wire                     rst_i,
    input  wire scaler_pkg::video_beat_t vid_i,
    input  wire scaler_pkg::rd_req_t     rd_req_i,
    output logic                    line_edge_o,
    output logic                    frame_edge_o,
    output scaler_pkg::tap_beat_t   tap_o
);
    import scaler_pkg::*;

    localparam int NUM_BUFS = 5;

    // two input register stages
    video_beat_t in_q;
    video_beat_t in_qq;

    // five rotating line buffers
    pixel_t line_mem [0:NUM_BUFS-1][0:`SCALER_LINE_MAX-1];

    // buffer being filled and its write address
    logic [2:0] buf_idx;
    addr_t      wr_addr;

    // slot for the current write, edges applied
    logic [2:0] wr_sel;
    addr_t      wr_addr_sel;

    // rotation for the line being read
    logic [2:0] rot_q;
    logic [2:0] rot_sel;

    // buffer n lines back from idx, modulo 5
    function automatic logic [2:0] buf_back(input logic [2:0] idx, input logic [2:0] n);
        logic [3:0] s;
        s = {1'b0, idx} + 4'd5 - {1'b0, n};
        return (s >= 4'd5) ? 3'(s - 4'd5) : s[2:0];
    endfunction

    always_ff @(posedge clk) begin
        if (rst_i) begin
            in_q  <= '0;
            in_qq <= '0;
        end else begin
            in_q  <= vid_i;
            in_qq <= in_q;
        end
    end

    // hs rising only outside vertical blanking
    always_ff @(posedge clk) begin
        if (rst_i) begin
            line_edge_o  <= 1'b0;
            frame_edge_o <= 1'b0;
        end else begin
            line_edge_o  <= in_q.hs && !in_qq.hs && !in_q.vs;
            frame_edge_o <= !in_q.vs && in_qq.vs;
        end
    end

    // frame edge wins over line edge
    always_comb begin
        wr_sel      = buf_idx;
        wr_addr_sel = wr_addr;
        if (frame_edge_o) begin
            wr_sel      = 3'd0;
            wr_addr_sel = '0;
        end else if (line_edge_o) begin
            wr_sel      = (buf_idx == 3'd4) ? 3'd0 : buf_idx + 3'd1;
            wr_addr_sel = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            buf_idx <= 3'd0;
            wr_addr <= '0;
        end else begin
            buf_idx <= wr_sel;
            // address steps only on active pixels
            wr_addr <= in_qq.de ? wr_addr_sel + 1'b1 : wr_addr_sel;
        end
    end

    always_ff @(posedge clk) begin
        if (in_qq.de) begin
            line_mem[wr_sel][wr_addr_sel] <= in_qq.data;
        end
    end

    // rotation frozen at the first read of a line
    assign rot_sel = (rd_req_i.valid && rd_req_i.first) ? buf_idx : rot_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            rot_q <= 3'd0;
        end else if (rd_req_i.valid && rd_req_i.first) begin
            rot_q <= buf_idx;
        end
    end

    // registered column read, p0 one line back .. p3 four back
    always_ff @(posedge clk) begin
        for (int k = 0; k < 4; k++) begin
            tap_o.taps[k] <= line_mem[buf_back(rot_sel, 3'(k + 1))][rd_req_i.addr];
        end
        if (rst_i) begin
            tap_o.de <= 1'b0;
            tap_o.hs <= 1'b0;
            tap_o.vs <= 1'b0;
        end else begin
            tap_o.de <= rd_req_i.valid;
            tap_o.hs <= rd_req_i.valid && rd_req_i.first;
            tap_o.vs <= in_q.vs;
        end
    end

endmodule

`default_nettype wire

/* hdl/row_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

`include "scaler_config.svh"

module row_sequencer (
    input  wire                          clk,
    input  wire                          rst_i,
    input  wire scaler_pkg::scale_cfg_t  cfg_i,
    input  wire                          line_edge_i,
    input  wire                          frame_edge_i,
    output scaler_pkg::rd_req_t          rd_req_o,
    output logic [`SCALER_PHASE_BITS-1:0] phase_o
);
    import scaler_pkg::*;

    localparam logic [23:0] STEP_IN   = 24'(`SCALER_STEP_IN);
    localparam logic [23:0] CORD_O_0  = 24'(3 * `SCALER_STEP_IN);
    localparam logic [3:0]  PACE_LAST = 4'(`SCALER_SPARSE);

    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        READ
    } state_t;

    state_t state;

    // nothing runs until the first frame edge
    logic armed;

    // line coordinates, 4.12 fixed point
    logic [23:0] cord_i;
    logic [23:0] cord_o;

    logic [15:0] rd_cnt;
    logic [3:0]  pace_cnt;
    logic [`SCALER_PHASE_BITS-1:0] phase_q;

    logic fire;

    // one request per pacing period
    assign fire = (state == READ) && (pace_cnt == PACE_LAST);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state    <= IDLE;
            armed    <= 1'b0;
            cord_i   <= '0;
            cord_o   <= '0;
            rd_cnt   <= '0;
            pace_cnt <= '0;
            phase_q  <= '0;
        end else if (frame_edge_i) begin
            // restart both coordinates, abort any line
            armed  <= 1'b1;
            cord_i <= '0;
            cord_o <= CORD_O_0;
            state  <= IDLE;
        end else begin
            if (line_edge_i) begin
                cord_i <= cord_i + STEP_IN;
            end
            case (state)
                IDLE: begin
                    // input has passed the output line
                    if (armed && (cord_i > cord_o)) begin
                        phase_q <= cord_o[11 -: `SCALER_PHASE_BITS];
                        state   <= SETUP;
                    end
                end
                SETUP: begin
                    // gives the rom a cycle on the new phase
                    rd_cnt   <= '0;
                    pace_cnt <= '0;
                    state    <= READ;
                end
                READ: begin
                    if (fire) begin
                        pace_cnt <= '0;
                        rd_cnt   <= rd_cnt + 16'd1;
                        if (rd_cnt == cfg_i.line_size - 16'd1) begin
                            cord_o <= cord_o + {8'd0, cfg_i.step_o};
                            state  <= IDLE;
                        end
                    end else begin
                        pace_cnt <= pace_cnt + 4'd1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign rd_req_o = '{
        valid: fire,
        first: fire && (rd_cnt == 16'd0),
        addr:  addr_t'(rd_cnt)
    };

    assign phase_o = phase_q;

endmodule

`default_nettype wire

/* hdl/cubic_coe_rom.sv */
`timescale 1ns/10ps
`default_nettype none

`include "scaler_config.svh"

module cubic_coe_rom (
    input  wire                          clk,
    input  wire [`SCALER_PHASE_BITS-1:0] phase_i,
    output scaler_pkg::coe_set_t         coe_o
);
    import scaler_pkg::*;

    localparam int PHASES = 1 << `SCALER_PHASE_BITS;
    localparam int UNITY  = 1 << (`SCALER_COE_WIDTH - 1);

    // catmull-rom weights for t = k / PHASES, rounded to nearest
    function automatic coe_set_t coe_row(input int k);
        int n;
        int half;
        int den;
        int c0;
        int c1;
        int c2;
        int c3;
        n    = PHASES;
        half = UNITY / 2;
        den  = n * n * n;
        c0   = (half * (n * n * k - 2 * n * k * k + k * k * k) + den / 2) / den;
        c2   = (half * (n * n * k + 4 * n * k * k - 3 * k * k * k) + den / 2) / den;
        // magnitude, the tap is subtracted
        c3   = (half * (n * k * k - k * k * k) + den / 2) / den;
        // signed weights always sum to unity
        c1   = UNITY - c2 + c0 + c3;
        return '{c0: coe_t'(c0), c1: coe_t'(c1), c2: coe_t'(c2), c3: coe_t'(c3)};
    endfunction

    coe_set_t rom_table [0:PHASES-1];

    // table is constant, built at elaboration
    for (genvar k = 0; k < PHASES; k++) begin : g_row
        localparam coe_set_t ROW = coe_row(k);
        assign rom_table[k] = ROW;
    end

    always_ff @(posedge clk) begin
        coe_o <= rom_table[phase_i];
    end

endmodule

`default_nettype wire

/* hdl/tap_filter.sv */
`timescale 1ns/10ps
`default_nettype none

`include "scaler_config.svh"

module tap_filter (
    input  wire                         clk,
    input  wire                         rst_i,
    input  wire scaler_pkg::tap_beat_t  tap_i,
    input  wire scaler_pkg::coe_set_t   coe_i,
    output scaler_pkg::video_beat_t     vid_o
);
    import scaler_pkg::*;

    localparam int DW    = `SCALER_DATA_WIDTH;
    localparam int CW    = `SCALER_COE_WIDTH;
    localparam int MUL_W = DW + CW;
    // two extra bits for sign and headroom
    localparam int SUM_W = MUL_W + 2;
    // half an lsb after the shift
    localparam logic [SUM_W-1:0] ROUND = SUM_W'(1) << (CW - 2);

    logic [MUL_W-1:0] mult [0:3];
    logic signed [SUM_W-1:0] sum;

    // {de, hs, vs} per stage
    logic [2:0] strb1;
    logic [2:0] strb2;

    // stage 1, unsigned products
    always_ff @(posedge clk) begin
        mult[0] <= coe_i.c0 * tap_i.taps[0];
        mult[1] <= coe_i.c1 * tap_i.taps[1];
        mult[2] <= coe_i.c2 * tap_i.taps[2];
        mult[3] <= coe_i.c3 * tap_i.taps[3];
    end

    // stage 2, outer taps carry negative weight
    always_ff @(posedge clk) begin
        sum <= SUM_W'(mult[1]) + SUM_W'(mult[2])
             - SUM_W'(mult[0]) - SUM_W'(mult[3]) + ROUND;
    end

    // stage 3, scale down and clamp
    always_ff @(posedge clk) begin
        if (sum[SUM_W-1]) begin
            vid_o.data <= '0;
        end else if (|sum[SUM_W-2 : CW-1+DW]) begin
            vid_o.data <= '1;
        end else begin
            vid_o.data <= sum[CW-1 +: DW];
        end
    end

    // strobes follow the three data stages
    always_ff @(posedge clk) begin
        if (rst_i) begin
            strb1    <= 3'b000;
            strb2    <= 3'b000;
            vid_o.de <= 1'b0;
            vid_o.hs <= 1'b0;
            vid_o.vs <= 1'b0;
        end else begin
            strb1    <= {tap_i.de, tap_i.hs, tap_i.vs};
            strb2    <= strb1;
            vid_o.de <= strb2[2];
            vid_o.hs <= strb2[1];
            vid_o.vs <= strb2[0];
        end
    end

endmodule

`default_nettype wire

/* hdl/vertical_scaler.sv */
`timescale 1ns/10ps
`default_nettype none

`include "scaler_config.svh"

module vertical_scaler (
    input  wire                          clk,
    input  wire                          rst_i,
    input  wire scaler_pkg::scale_cfg_t  cfg_i,
    input  wire scaler_pkg::video_beat_t vid_i,
    output scaler_pkg::video_beat_t      vid_o
);
    import scaler_pkg::*;

    // edges from the input side
    logic line_edge;
    logic frame_edge;

    // sequencer to store and rom
    rd_req_t rd_req;
    logic [`SCALER_PHASE_BITS-1:0] phase;

    // store and rom to filter
    tap_beat_t tap;
    coe_set_t  coe;

    line_store u_line_store (
        .clk          (clk),
        .rst_i        (rst_i),
        .vid_i        (vid_i),
        .rd_req_i     (rd_req),
        .line_edge_o  (line_edge),
        .frame_edge_o (frame_edge),
        .tap_o        (tap)
    );

    row_sequencer u_row_sequencer (
        .clk          (clk),
        .rst_i        (rst_i),
        .cfg_i        (cfg_i),
        .line_edge_i  (line_edge),
        .frame_edge_i (frame_edge),
        .rd_req_o     (rd_req),
        .phase_o      (phase)
    );

    // weights settle during the setup cycle
    cubic_coe_rom u_cubic_coe_rom (
        .clk     (clk),
        .phase_i (phase),
        .coe_o   (coe)
    );

    tap_filter u_tap_filter (
        .clk   (clk),
        .rst_i (rst_i),
        .tap_i (tap),
        .coe_i (coe),
        .vid_o (vid_o)
    );

endmodule

`default_nettype wire

/* bench/scaler_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "scaler_config.svh"

module scaler_tb;
    import scaler_pkg::*;

    localparam int UNITY       = 1 << (`SCALER_COE_WIDTH - 1);
    localparam int PHASES      = 1 << `SCALER_PHASE_BITS;
    localparam int MODE_RANDOM = 0;
    localparam int MODE_FLAT   = 1;
    localparam int MODE_BARS   = 2;
    // vs high beats at the start of every frame
    localparam int VS_BEATS    = 4;

    logic        clk;
    logic        rst_i;
    scale_cfg_t  cfg_i;
    video_beat_t vid_i;
    video_beat_t vid_o;

    // reference copy of the five line buffers and the fill index
    pixel_t model_buf [0:4][0:`SCALER_LINE_MAX-1];
    pixel_t frame_rows [0:15][0:`SCALER_LINE_MAX-1];
    int     m_idx = 0;

    // expected and collected output of one frame
    pixel_t exp_pix [$];
    pixel_t got_pix [$];
    int     got_len [$];
    int     exp_lines;
    int     n_over;
    int     n_under;

    int          errors = 0;
    int          strobe_seen = 0;
    int          vs_seen = 0;
    int          cycle_no = 0;
    int          last_de = 0;
    logic [15:0] lfsr_state = 16'd51548;

    vertical_scaler dut0 (
        .clk   (clk),
        .rst_i (rst_i),
        .cfg_i (cfg_i),
        .vid_i (vid_i),
        .vid_o (vid_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_run();
        errors++;
        $display("CHECKS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        stop_run();
    endtask

    task automatic check_pixel(input string name, input pixel_t exp, input pixel_t act);
        if (exp !== act) begin
            $display("Mismatch %s: expected %0d, actual %0d", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (exp != act) begin
            $display("Mismatch %s: expected %0d, actual %0d", name, exp, act);
            stop_run();
        end
    endtask

    // galois lfsr, x^16 + x^14 + x^13 + x^11 + 1, one step per bit
    function automatic pixel_t random_pixel();
        pixel_t v;
        logic   b;
        v = '0;
        for (int i = 0; i < `SCALER_DATA_WIDTH; i++) begin
            b          = lfsr_state[0];
            lfsr_state = {1'b0, lfsr_state[15:1]} ^ (b ? 16'hB400 : 16'h0000);
            v          = {v[`SCALER_DATA_WIDTH-2:0], b};
        end
        return v;
    endfunction

    // bars come in pairs of rows so two bright rows sit between dark ones
    function automatic pixel_t row_value(input int mode, input pixel_t level,
                                         input int r, input int x);
        if (mode == MODE_FLAT) begin
            return level;
        end else if (mode == MODE_BARS) begin
            return (((r >> 1) ^ x) & 1) ? 8'd255 : 8'd0;
        end
        return random_pixel();
    endfunction

    // catmull-rom magnitude for tap j, straight from the kernel polynomials
    function automatic int cubic_weight(input int ph, input int j);
        real t;
        real w;
        t = real'(ph) / real'(PHASES);
        case (j)
            0:       w = (t - 2.0 * t * t + t * t * t) * UNITY / 2.0;
            2:       w = (t + 4.0 * t * t - 3.0 * t * t * t) * UNITY / 2.0;
            3:       w = (t * t - t * t * t) * UNITY / 2.0;
            default: w = 0.0;
        endcase
        return $rtoi(w + 0.5);
    endfunction

    // room for every output line that one input row can trigger
    function automatic int blank_cycles(input int ls, input int step);
        return ((`SCALER_STEP_IN + step - 1) / step + 1) * (3 * ls + 8) + 8;
    endfunction

    function automatic int frame_cycles(input int ls, input int step, input int nrows);
        return 8 + nrows * (1 + ls + blank_cycles(ls, step)) + 4 * ls + 100;
    endfunction

    task automatic drive_beat(input logic de, input logic hs, input logic vs, input pixel_t data);
        @(posedge clk);
        #1;
        vid_i = '{data: data, de: de, hs: hs, vs: vs};
    endtask

    // hs pulse, active pixels, then blanking
    task automatic drive_row(input int r, input int ls, input int blank);
        drive_beat(1'b0, 1'b1, 1'b0, '0);
        for (int x = 0; x < ls; x++) begin
            drive_beat(1'b1, 1'b0, 1'b0, frame_rows[r][x]);
        end
        repeat (blank) drive_beat(1'b0, 1'b0, 1'b0, '0);
    endtask

    // one output line at coordinate co, taps one to four buffers back
    task automatic predict_line(input int co, input int ls);
        int ph;
        int c0;
        int c1;
        int c2;
        int c3;
        int s;
        ph = (co >> 7) % PHASES;
        c0 = cubic_weight(ph, 0);
        c2 = cubic_weight(ph, 2);
        c3 = cubic_weight(ph, 3);
        c1 = UNITY - c2 + c0 + c3;
        for (int x = 0; x < ls; x++) begin
            s = -c0 * int'(model_buf[(m_idx + 4) % 5][x])
                + c1 * int'(model_buf[(m_idx + 3) % 5][x])
                + c2 * int'(model_buf[(m_idx + 2) % 5][x])
                - c3 * int'(model_buf[(m_idx + 1) % 5][x])
                + UNITY / 2;
            if (s < 0) begin
                n_under++;
                exp_pix.push_back(8'd0);
            end else if ((s >>> (`SCALER_COE_WIDTH - 1)) > 255) begin
                n_over++;
                exp_pix.push_back(8'd255);
            end else begin
                exp_pix.push_back(pixel_t'(s >>> (`SCALER_COE_WIDTH - 1)));
            end
        end
        exp_lines++;
    endtask

    task automatic wait_output(input int n_pix, input int limit);
        int waited;
        waited = 0;
        while (got_pix.size() < n_pix) begin
            @(posedge clk);
            waited++;
            if (waited > limit) begin
                report_failure("output pixels did not arrive in time");
            end
        end
    endtask

    // frame edge, rows with the model stepping the coordinates alongside
    task automatic run_frame(input string name, input int ls, input int step,
                             input int nrows, input int mode, input pixel_t level);
        int cord_i;
        int cord_o;
        int blank;
        blank = blank_cycles(ls, step);
        exp_pix.delete();
        got_pix.delete();
        got_len.delete();
        exp_lines = 0;
        n_over    = 0;
        n_under   = 0;
        vs_seen   = 0;
        cord_i    = 0;
        cord_o    = 3 * `SCALER_STEP_IN;
        m_idx     = 0;
        cfg_i     = '{step_o: 16'(step), line_size: 16'(ls)};
        repeat (VS_BEATS) drive_beat(1'b0, 1'b0, 1'b1, '0);
        repeat (4) drive_beat(1'b0, 1'b0, 1'b0, '0);
        for (int r = 0; r < nrows; r++) begin
            for (int x = 0; x < ls; x++) begin
                frame_rows[r][x] = row_value(mode, level, r, x);
            end
            // line edge moves the index and the input coordinate
            m_idx  = (m_idx + 1) % 5;
            cord_i = cord_i + `SCALER_STEP_IN;
            while (cord_i > cord_o) begin
                predict_line(cord_o, ls);
                cord_o = cord_o + step;
            end
            for (int x = 0; x < ls; x++) begin
                model_buf[m_idx][x] = frame_rows[r][x];
            end
            drive_row(r, ls, blank);
        end
        wait_output(exp_lines * ls, 4 * ls + 100);
        // vs is delayed alongside the data, never stretched or dropped
        check_count({name, " vs beats"}, VS_BEATS, vs_seen);
        check_count({name, " lines"}, exp_lines, got_len.size());
        foreach (got_len[i]) begin
            check_count({name, " pixels per line"}, ls, got_len[i]);
        end
        foreach (exp_pix[i]) begin
            check_pixel(name, exp_pix[i], got_pix[i]);
        end
    endtask

    task automatic check_all_equal(input string name, input pixel_t level);
        foreach (got_pix[i]) begin
            check_pixel(name, level, got_pix[i]);
        end
    endtask

    // five full rows with vs low fill every buffer, no output allowed
    task automatic test_idle_before_frame();
        strobe_seen = 0;
        for (int r = 0; r < 5; r++) begin
            for (int x = 0; x < `SCALER_LINE_MAX; x++) begin
                frame_rows[r][x] = random_pixel();
            end
            m_idx = (m_idx + 1) % 5;
            for (int x = 0; x < `SCALER_LINE_MAX; x++) begin
                model_buf[m_idx][x] = frame_rows[r][x];
            end
            drive_row(r, `SCALER_LINE_MAX, 4);
        end
        check_count("idle before frame strobes", 0, strobe_seen);
    endtask

    // phase stays zero so output line k is input line k plus one
    task automatic test_unity_step();
        run_frame("unity", 16, 4096, 8, MODE_RANDOM, '0);
        for (int k = 0; k < got_len.size(); k++) begin
            for (int x = 0; x < 16; x++) begin
                check_pixel("unity copy", frame_rows[k + 1][x], got_pix[k * 16 + x]);
            end
        end
    endtask

    task automatic test_flat_field();
        // unity frame first so all five buffers hold the field
        run_frame("flat 4096", 20, 4096, 8, MODE_FLAT, 8'd137);
        check_all_equal("flat 4096 level", 8'd137);
        run_frame("flat 3072", 20, 3072, 8, MODE_FLAT, 8'd137);
        check_all_equal("flat 3072 level", 8'd137);
        run_frame("flat 6144", 20, 6144, 8, MODE_FLAT, 8'd137);
        check_all_equal("flat 6144 level", 8'd137);
    endtask

    task automatic test_random_rows();
        run_frame("random 2730", 24, 2730, 10, MODE_RANDOM, '0);
    endtask

    task automatic test_clamped_bars();
        run_frame("bars", 16, 2730, 10, MODE_BARS, '0);
        if (n_over == 0 || n_under == 0) begin
            report_failure("bar pattern did not reach both clamp limits");
        end
    endtask

    // second frame has its own size and step
    task automatic test_frame_restart();
        run_frame("restart a", 12, 3500, 8, MODE_RANDOM, '0);
        run_frame("restart b", 40, 5000, 9, MODE_RANDOM, '0);
    endtask

    // beats sampled away from the active edge
    always @(negedge clk) begin
        cycle_no++;
        if (!rst_i) begin
            if (vid_o.de || vid_o.hs || vid_o.vs) begin
                strobe_seen++;
            end
            if (vid_o.vs) begin
                vs_seen++;
            end
            if (vid_o.hs && !vid_o.de) begin
                report_failure("output hs seen without de");
            end
            if (vid_o.de) begin
                if (vid_o.hs) begin
                    got_len.push_back(0);
                end else if (got_len.size() == 0) begin
                    report_failure("output de seen before any hs");
                end else if (cycle_no - last_de != `SCALER_SPARSE + 1) begin
                    report_failure("output pixels of a line are not evenly spaced");
                end
                if (got_len.size() != 0) begin
                    got_len[got_len.size() - 1] = got_len[got_len.size() - 1] + 1;
                end
                got_pix.push_back(vid_o.data);
                last_de = cycle_no;
            end
        end
    end

    initial begin : watchdog
        int budget;
        budget = 5 * (1 + `SCALER_LINE_MAX + 4) + 20
               + frame_cycles(16, 4096, 8)
               + frame_cycles(20, 4096, 8)
               + frame_cycles(20, 3072, 8)
               + frame_cycles(20, 6144, 8)
               + frame_cycles(24, 2730, 10)
               + frame_cycles(16, 2730, 10)
               + frame_cycles(12, 3500, 8)
               + frame_cycles(40, 5000, 9)
               + 500;
        repeat (budget) @(posedge clk);
        $display("watchdog expired before the tests finished");
        stop_run();
    end

    initial begin
        rst_i = 1'b1;
        cfg_i = '0;
        vid_i = '0;
        repeat (3) @(posedge clk);
        #1;
        rst_i = 1'b0;
        test_idle_before_frame();
        test_unity_step();
        test_flat_field();
        test_random_rows();
        test_clamped_bars();
        test_frame_restart();
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+include
hdl/scaler_pkg.sv
hdl/line_store.sv
hdl/row_sequencer.sv
hdl/cubic_coe_rom.sv
hdl/tap_filter.sv
hdl/vertical_scaler.sv
bench/scaler_tb.sv

/* Bender.yml */
package:
  name: vertical_scaler

export_include_dirs:
  - include

sources:
  - files:
      - hdl/scaler_pkg.sv
      - hdl/line_store.sv
      - hdl/row_sequencer.sv
      - hdl/cubic_coe_rom.sv
      - hdl/tap_filter.sv
      - hdl/vertical_scaler.sv
  - target: test
    files:
      - bench/scaler_tb.sv
